// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_frontend
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat list.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bpu/bpu.sv
// Branch prediction unit
// Gshare two-bit counters and a direct-mapped BTB

`timescale 1ns/1ps
`default_nettype none

module bpu #(
  parameter int unsigned HLEN     = frontend_pkg::DEF_HLEN,
  parameter int unsigned BTB_BITS = frontend_pkg::DEF_BTB_BITS
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          flush_i,
  // Fetch PC
  input  logic [frontend_pkg::XLEN-1:0] pc_i,
  // Resolution from execute
  input  logic                          res_valid_i,
  input  logic [frontend_pkg::XLEN-1:0] res_pc_i,
  input  logic [frontend_pkg::XLEN-1:0] res_target_i,
  input  logic                          res_taken_i,
  // Prediction for pc_i
  output logic                          pred_taken_o,
  output logic [frontend_pkg::XLEN-1:0] pred_target_o
);

  import frontend_pkg::*;

  localparam int unsigned PHT_SIZE = 1 << HLEN;
  localparam int unsigned BTB_SIZE = 1 << BTB_BITS;
  localparam int unsigned TAG_W    = XLEN - BTB_BITS - 2;

  // Global history, newest outcome in bit 0
  logic [HLEN-1:0]     ghr_q;
  logic [1:0]          pht_q [PHT_SIZE];
  logic [BTB_SIZE-1:0] btb_valid_q;
  logic [TAG_W-1:0]    btb_tag_q [BTB_SIZE];
  logic [XLEN-1:0]     btb_target_q [BTB_SIZE];
  logic [HLEN-1:0]     pred_idx;
  logic [HLEN-1:0]     res_idx;
  logic [BTB_BITS-1:0] pred_btb_idx;
  logic [BTB_BITS-1:0] res_btb_idx;
  logic                btb_hit;

  // Gshare index
  assign pred_idx = pc_i[HLEN+1:2] ^ ghr_q;
  assign res_idx  = res_pc_i[HLEN+1:2] ^ ghr_q;

  assign pred_btb_idx = pc_i[BTB_BITS+1:2];
  assign res_btb_idx  = res_pc_i[BTB_BITS+1:2];

  // -------------------------------------------------------------------
  // Lookup
  // -------------------------------------------------------------------
  assign btb_hit = btb_valid_q[pred_btb_idx] &
                   (btb_tag_q[pred_btb_idx] == pc_i[XLEN-1:BTB_BITS+2]);

  // Taken only with a strong enough counter and a known target
  assign pred_taken_o  = pht_q[pred_idx][1] & btb_hit;
  assign pred_target_o = btb_target_q[pred_btb_idx];

  // -------------------------------------------------------------------
  // Update
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ghr_q <= '0;
    end else if (flush_i) begin
      ghr_q <= '0;
    end else if (res_valid_i) begin
      ghr_q <= {ghr_q[HLEN-2:0], res_taken_i};
    end
  end

  // Counters start weakly not-taken and saturate
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < PHT_SIZE; i++) begin
        pht_q[i] <= 2'b01;
      end
    end else if (res_valid_i) begin
      if (res_taken_i && pht_q[res_idx] != 2'b11) begin
        pht_q[res_idx] <= pht_q[res_idx] + 2'd1;
      end else if (!res_taken_i && pht_q[res_idx] != 2'b00) begin
        pht_q[res_idx] <= pht_q[res_idx] - 2'd1;
      end
    end
  end

  // Flush forgets every target
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      btb_valid_q <= '0;
    end else if (flush_i) begin
      btb_valid_q <= '0;
    end else if (res_valid_i && res_taken_i) begin
      btb_valid_q[res_btb_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_taken_i) begin
      btb_tag_q[res_btb_idx]    <= res_pc_i[XLEN-1:BTB_BITS+2];
      btb_target_q[res_btb_idx] <= res_target_i;
    end
  end

endmodule

`default_nettype wire

// File: common/frontend_pkg.sv
// Front end package
// Shared widths, exception codes, bus states and predictor defaults

`default_nettype none

package frontend_pkg;

  // -------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------
  // Address width
  localparam int unsigned XLEN = 32;
  // Instruction word width
  localparam int unsigned ILEN = 32;

  // -------------------------------------------------------------------
  // Exception codes
  // -------------------------------------------------------------------
  // Values follow the RISC-V mcause numbering
  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGNED   = 4'd0,
    EXC_INSTR_ACCESS_FAULT = 4'd1,
    // No fault, outside the mcause range used here
    EXC_NONE               = 4'hf
  } except_code_e;

  // Wishbone master states
  typedef enum logic {
    WB_IDLE,
    WB_WAIT
  } wb_state_e;

  // -------------------------------------------------------------------
  // Predictor and boot defaults
  // -------------------------------------------------------------------
  // Global history length
  localparam int unsigned DEF_HLEN = 4;
  // BTB index width
  localparam int unsigned DEF_BTB_BITS = 4;
  // Reset PC
  localparam logic [XLEN-1:0] BOOT_PC = '0;

endpackage

`default_nettype wire

// File: fetch_stage/fetch_stage.sv
// Fetch stage
// Bus master, fetch unit and branch predictor with flush steering

`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter int unsigned HLEN     = frontend_pkg::DEF_HLEN,
  parameter int unsigned BTB_BITS = frontend_pkg::DEF_BTB_BITS
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          flush_i,
  // PC generator side
  input  logic [frontend_pkg::XLEN-1:0] pc_i,
  output logic                          fetch_ready_o,
  output logic                          next_taken_o,
  output logic [frontend_pkg::XLEN-1:0] next_target_o,
  // Wishbone classic master
  output logic [frontend_pkg::XLEN-1:0] wb_adr_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [3:0]                    wb_sel_o,
  input  logic [frontend_pkg::ILEN-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i,
  // Toward decode
  input  logic                          issue_ready_i,
  output logic                          issue_valid_o,
  output logic [frontend_pkg::ILEN-1:0] instruction_o,
  output logic [frontend_pkg::XLEN-1:0] curr_pc_o,
  output logic                          pred_taken_o,
  output logic [frontend_pkg::XLEN-1:0] pred_target_o,
  output logic                          except_o,
  output frontend_pkg::except_code_e    except_code_o,
  // Branch resolution
  input  logic                          res_valid_i,
  input  logic [frontend_pkg::XLEN-1:0] res_pc_i,
  input  logic [frontend_pkg::XLEN-1:0] res_target_i,
  input  logic                          res_taken_i,
  input  logic                          res_mispredict_i
);

  import frontend_pkg::*;

  logic            mispredict;
  logic            flush_all;
  logic            bpu_flush;
  logic            read_req;
  logic            read_done;
  logic [ILEN-1:0] bus_instr;
  except_code_e    bus_exc;

  // Mispredict flushes fetch but keeps the trained predictor
  assign mispredict = res_valid_i & res_mispredict_i;
  assign flush_all  = flush_i | mispredict;
  assign bpu_flush  = flush_i & ~mispredict;

  // -------------------------------------------------------------------
  // Bus master
  // -------------------------------------------------------------------
  imem_wb_master u_imem_wb_master (
    .flush_i      (flush_all),
    .read_req_i   (read_req),
    .instr_o      (bus_instr),
    .except_code_o(bus_exc),
    .read_done_o  (read_done),
    .*
  );

  // -------------------------------------------------------------------
  // Fetch unit
  // -------------------------------------------------------------------
  ifu u_ifu (
    .flush_i      (flush_all),
    .pred_taken_i (next_taken_o),
    .pred_target_i(next_target_o),
    .instr_i      (bus_instr),
    .except_code_i(bus_exc),
    .read_done_i  (read_done),
    .read_req_o   (read_req),
    .*
  );

  // -------------------------------------------------------------------
  // Branch predictor
  // -------------------------------------------------------------------
  bpu #(
    .HLEN    (HLEN),
    .BTB_BITS(BTB_BITS)
  ) u_bpu (
    .flush_i      (bpu_flush),
    .pred_taken_o (next_taken_o),
    .pred_target_o(next_target_o),
    .*
  );

endmodule

`default_nettype wire

// File: fetch_stage/ifu.sv
// Instruction fetch unit
// Request control and output register toward decode

`timescale 1ns/1ps
`default_nettype none

module ifu (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          flush_i,
  // PC and its prediction
  input  logic [frontend_pkg::XLEN-1:0] pc_i,
  input  logic                          pred_taken_i,
  input  logic [frontend_pkg::XLEN-1:0] pred_target_i,
  // Bus master
  input  logic [frontend_pkg::ILEN-1:0] instr_i,
  input  frontend_pkg::except_code_e    except_code_i,
  input  logic                          read_done_i,
  output logic                          read_req_o,
  output logic                          fetch_ready_o,
  // Toward decode
  input  logic                          issue_ready_i,
  output logic                          issue_valid_o,
  output logic [frontend_pkg::ILEN-1:0] instruction_o,
  output logic [frontend_pkg::XLEN-1:0] curr_pc_o,
  output logic                          pred_taken_o,
  output logic [frontend_pkg::XLEN-1:0] pred_target_o,
  output logic                          except_o,
  output frontend_pkg::except_code_e    except_code_o
);

  import frontend_pkg::*;

  // Control state
  logic            busy_q;
  logic            got_q;
  logic            discard_q;
  // PC and prediction of the word on the bus
  logic [XLEN-1:0] pend_pc_q;
  logic            pend_taken_q;
  logic [XLEN-1:0] pend_target_q;
  logic            room;
  logic            arrived;
  logic            load;

  // Register empty or handed to decode this cycle
  assign room    = ~issue_valid_o | issue_ready_i;
  // Fresh word from the bus, or one parked in the master
  assign arrived = (read_done_i & ~discard_q) | got_q;
  assign load    = arrived & room & ~flush_i;

  // New request once the bus frees and the register has room
  assign fetch_ready_o = ~flush_i & room & (~busy_q | read_done_i);
  assign read_req_o    = fetch_ready_o;

  // -------------------------------------------------------------------
  // Control
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q        <= 1'b0;
      got_q         <= 1'b0;
      discard_q     <= 1'b0;
      issue_valid_o <= 1'b0;
    end else begin
      if (read_req_o) begin
        busy_q <= 1'b1;
      end else if (read_done_i) begin
        busy_q <= 1'b0;
      end
      if (flush_i) begin
        issue_valid_o <= 1'b0;
        got_q         <= 1'b0;
        // Word still on the bus is dropped at its done
        discard_q     <= busy_q & ~read_done_i;
      end else begin
        if (load) begin
          issue_valid_o <= 1'b1;
        end else if (issue_ready_i) begin
          issue_valid_o <= 1'b0;
        end
        // Word waits in the master while decode stalls
        got_q <= arrived & ~room;
        if (read_done_i) begin
          discard_q <= 1'b0;
        end
      end
    end
  end

  // -------------------------------------------------------------------
  // Payload
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (read_req_o) begin
      pend_pc_q     <= pc_i;
      pend_taken_q  <= pred_taken_i;
      pend_target_q <= pred_target_i;
    end
    if (load) begin
      instruction_o <= instr_i;
      curr_pc_o     <= pend_pc_q;
      pred_taken_o  <= pend_taken_q;
      pred_target_o <= pend_target_q;
      except_code_o <= except_code_i;
    end
  end

  assign except_o = issue_valid_o & (except_code_o != EXC_NONE);

endmodule

`default_nettype wire

// File: fetch_stage/imem_wb_master.sv
// Instruction memory Wishbone classic master
// One read per request, with access and alignment fault reporting

`timescale 1ns/1ps
`default_nettype none

module imem_wb_master (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          flush_i,
  // Request from the fetch unit
  input  logic [frontend_pkg::XLEN-1:0] pc_i,
  input  logic                          read_req_i,
  // Wishbone classic
  output logic [frontend_pkg::XLEN-1:0] wb_adr_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [3:0]                    wb_sel_o,
  input  logic [frontend_pkg::ILEN-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i,
  // Result toward the fetch unit
  output logic [frontend_pkg::ILEN-1:0] instr_o,
  output frontend_pkg::except_code_e    except_code_o,
  output logic                          read_done_o
);

  import frontend_pkg::*;

  wb_state_e       state_q;
  logic            accept;
  logic            misaligned;
  logic            bus_end;
  // Pending alignment fault, reported one cycle after its request
  logic            mis_q;
  logic [XLEN-1:0] adr_q;
  // Last result, kept until the next one ends
  logic [ILEN-1:0] instr_q;
  except_code_e    exc_q;

  assign misaligned = |pc_i[1:0];
  assign bus_end    = (state_q == WB_WAIT) & (wb_ack_i | wb_err_i);
  // New request taken when idle or as the current cycle ends
  assign accept     = read_req_i & ~flush_i & ((state_q == WB_IDLE) | bus_end);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= WB_IDLE;
      mis_q   <= 1'b0;
    end else begin
      mis_q <= accept & misaligned;
      // Misaligned PC never starts a bus cycle
      if (accept && !misaligned) begin
        state_q <= WB_WAIT;
      end else if (bus_end) begin
        state_q <= WB_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q <= pc_i;
    end
    if (read_done_o) begin
      instr_q <= instr_o;
      exc_q   <= except_code_o;
    end
  end

  // Live bus data on ack or err, held copy otherwise
  always_comb begin
    instr_o       = instr_q;
    except_code_o = exc_q;
    if (bus_end) begin
      instr_o       = wb_dat_i;
      except_code_o = wb_err_i ? EXC_INSTR_ACCESS_FAULT : EXC_NONE;
    end else if (mis_q) begin
      except_code_o = EXC_INSTR_MISALIGNED;
    end
  end

  assign read_done_o = bus_end | mis_q;

  // Read only, full word
  assign wb_adr_o = adr_q;
  assign wb_cyc_o = (state_q == WB_WAIT);
  assign wb_stb_o = (state_q == WB_WAIT);
  assign wb_we_o  = 1'b0;
  assign wb_sel_o = 4'hf;

  wb_stb_cyc_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_o |-> wb_cyc_o);

  // Strobe and address hold until the slave answers
  wb_stb_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_o && !wb_ack_i && !wb_err_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

`default_nettype wire

// File: list.f
common/frontend_pkg.sv
source/pc_gen.sv
fetch_stage/imem_wb_master.sv
fetch_stage/ifu.sv
bpu/bpu.sv
fetch_stage/fetch_stage.sv
source/frontend_top.sv
tests/frontend_checker.sv
tests/tb_frontend.sv

// File: source/frontend_top.sv
// Instruction fetch front end
// PC generator plus fetch stage with Wishbone port and branch predictor

`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
  parameter int unsigned                   HLEN     = frontend_pkg::DEF_HLEN,
  parameter int unsigned                   BTB_BITS = frontend_pkg::DEF_BTB_BITS,
  parameter logic [frontend_pkg::XLEN-1:0] BOOT_PC  = frontend_pkg::BOOT_PC
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          flush_i,
  // Wishbone classic master
  output logic [frontend_pkg::XLEN-1:0] wb_adr_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [3:0]                    wb_sel_o,
  input  logic [frontend_pkg::ILEN-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i,
  // Toward decode
  input  logic                          issue_ready_i,
  output logic                          issue_valid_o,
  output logic [frontend_pkg::ILEN-1:0] instruction_o,
  output logic [frontend_pkg::XLEN-1:0] curr_pc_o,
  output logic                          pred_taken_o,
  output logic [frontend_pkg::XLEN-1:0] pred_target_o,
  // Fetch exceptions
  output logic                          except_o,
  output frontend_pkg::except_code_e    except_code_o,
  // Branch resolution from execute
  input  logic                          res_valid_i,
  input  logic [frontend_pkg::XLEN-1:0] res_pc_i,
  input  logic [frontend_pkg::XLEN-1:0] res_target_i,
  input  logic                          res_taken_i,
  input  logic                          res_mispredict_i
);

  import frontend_pkg::*;

  logic [XLEN-1:0] pc;
  logic            fetch_ready;
  logic            redirect;
  // Live prediction for the PC being fetched
  logic            next_taken;
  logic [XLEN-1:0] next_target;

  // Only a mispredicted branch moves the PC
  assign redirect = res_valid_i & res_mispredict_i;

  pc_gen #(
    .BOOT_PC(BOOT_PC)
  ) u_pc_gen (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .redirect_i   (redirect),
    .redirect_pc_i(res_target_i),
    .advance_i    (fetch_ready),
    .pred_taken_i (next_taken),
    .pred_target_i(next_target),
    .pc_o         (pc)
  );

  // Remaining ports share names with the top level
  fetch_stage #(
    .HLEN    (HLEN),
    .BTB_BITS(BTB_BITS)
  ) u_fetch_stage (
    .pc_i         (pc),
    .fetch_ready_o(fetch_ready),
    .next_taken_o (next_taken),
    .next_target_o(next_target),
    .*
  );

endmodule

`default_nettype wire

// File: source/pc_gen.sv
// Program counter generator
// Picks a redirect, a predicted target or the next sequential address

`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
  parameter logic [frontend_pkg::XLEN-1:0] BOOT_PC = frontend_pkg::BOOT_PC
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Redirect from branch resolution
  input  logic                          redirect_i,
  input  logic [frontend_pkg::XLEN-1:0] redirect_pc_i,
  // Fetch acceptance and prediction for the current PC
  input  logic                          advance_i,
  input  logic                          pred_taken_i,
  input  logic [frontend_pkg::XLEN-1:0] pred_target_i,
  output logic [frontend_pkg::XLEN-1:0] pc_o
);

  import frontend_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;

  // Redirect wins over any prediction
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (advance_i) begin
      // Follow the predictor for the PC just accepted
      pc_d = pred_taken_i ? pred_target_i : pc_q + XLEN'(4);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  // PC held while fetch stalls and no redirect comes in
  pc_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !advance_i && !redirect_i |=> $stable(pc_o));

endmodule

`default_nettype wire

// File: tests/frontend_checker.sv
// Front end checker
// Reference predictor model, issue order and payload checks

`timescale 1ns/1ps
`default_nettype none

module frontend_checker #(
  parameter logic [31:0] MEM_KEY = 32'h13579bdf,
  parameter logic [31:0] BOOT_PC = frontend_pkg::BOOT_PC
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       flush_i,
  input  logic                       issue_ready_i,
  input  logic                       issue_valid_i,
  input  logic [31:0]                instruction_i,
  input  logic [31:0]                curr_pc_i,
  input  logic                       pred_taken_i,
  input  logic [31:0]                pred_target_i,
  input  logic                       except_i,
  input  frontend_pkg::except_code_e except_code_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [3:0]                 wb_sel_i,
  input  logic [31:0]                wb_adr_i,
  input  logic                       res_valid_i,
  input  logic [31:0]                res_pc_i,
  input  logic [31:0]                res_target_i,
  input  logic                       res_taken_i,
  input  logic                       res_mispredict_i,
  output int                         issue_cnt_o,
  output int                         error_cnt_o
);

  import frontend_pkg::*;

  localparam int H = DEF_HLEN;
  localparam int B = DEF_BTB_BITS;

  // -------------------------------------------------------------------
  // Reference predictor state
  // -------------------------------------------------------------------
  logic [H-1:0] ghr;
  logic [1:0]   pht [1 << H];
  logic         btb_v [1 << B];
  logic [31:0]  btb_pc [1 << B];
  logic [31:0]  btb_tgt [1 << B];

  // Issue tracking
  int           cycle;
  int           last_change;
  int           redir_edge;
  int           iss1;
  int           iss2;
  bit           expect_known;
  logic [31:0]  expect_pc;
  bit           held;
  logic [31:0]  held_pc;
  logic [31:0]  held_instr;
  bit           redir;
  bit           fl;
  bit           bflush;
  int           idx;

  function automatic bit model_taken(input logic [31:0] pc);
    int pi;
    int bi;
    pi = int'(pc[H+1:2] ^ ghr);
    bi = int'(pc[B+1:2]);
    return pht[pi][1] && btb_v[bi] && (btb_pc[bi][31:B+2] == pc[31:B+2]);
  endfunction

  function automatic except_code_e expected_code(input logic [31:0] pc);
    if (pc[1:0] != 2'b00) begin
      return EXC_INSTR_MISALIGNED;
    end
    if (pc >= 32'h400) begin
      return EXC_INSTR_ACCESS_FAULT;
    end
    return EXC_NONE;
  endfunction

  task automatic report(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    error_cnt_o++;
  endtask

  task automatic check_issue();
    except_code_e exp_code;
    int           lower;
    bit           exp_tk;
    issue_cnt_o++;
    if (expect_known && curr_pc_i != expect_pc) begin
      report($sformatf("issued pc %h, expected %h", curr_pc_i, expect_pc));
    end
    exp_code = expected_code(curr_pc_i);
    if (except_code_i != exp_code || except_i != (exp_code != EXC_NONE)) begin
      report($sformatf("pc %h exception %s, expected %s", curr_pc_i,
                       except_code_i.name(), exp_code.name()));
    end
    if (exp_code == EXC_NONE && instruction_i != (curr_pc_i ^ MEM_KEY)) begin
      report($sformatf("pc %h instruction %h, expected %h", curr_pc_i,
                       instruction_i, curr_pc_i ^ MEM_KEY));
    end
    // Prediction was sampled no earlier than either bound
    lower = (iss2 > redir_edge + 1) ? iss2 : redir_edge + 1;
    if (last_change < lower) begin
      exp_tk = model_taken(curr_pc_i);
      if (pred_taken_i != exp_tk) begin
        report($sformatf("pc %h predicted %0b, expected %0b", curr_pc_i,
                         pred_taken_i, exp_tk));
      end else if (exp_tk && pred_target_i != btb_tgt[int'(curr_pc_i[B+1:2])]) begin
        report($sformatf("pc %h target %h wrong", curr_pc_i, pred_target_i));
      end
    end
    // Next issue follows the carried prediction
    expect_pc    = pred_taken_i ? pred_target_i : curr_pc_i + 32'd4;
    expect_known = 1'b1;
    iss2         = iss1;
    iss1         = cycle;
  endtask

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ghr          = '0;
      cycle        = 0;
      last_change  = -1;
      redir_edge   = -1;
      iss1         = -1;
      iss2         = -1;
      expect_known = 1'b1;
      expect_pc    = BOOT_PC;
      held         = 1'b0;
      issue_cnt_o  = 0;
      error_cnt_o  = 0;
      for (int i = 0; i < (1 << H); i++) begin
        pht[i] = 2'b01;
      end
      for (int i = 0; i < (1 << B); i++) begin
        btb_v[i] = 1'b0;
      end
    end else begin
      cycle++;
      redir  = res_valid_i & res_mispredict_i;
      fl     = flush_i | redir;
      bflush = flush_i & ~redir;
      if (wb_cyc_i && wb_adr_i[1:0] != 2'b00) begin
        report($sformatf("bus cycle started at misaligned %h", wb_adr_i));
      end
      // Read only bus cycles with strobe tied to cycle
      if (wb_stb_i != wb_cyc_i) begin
        report($sformatf("wb stb %0b with cyc %0b", wb_stb_i, wb_cyc_i));
      end
      if (wb_cyc_i && (wb_we_i || wb_sel_i != 4'hf)) begin
        report($sformatf("bus cycle with we %0b sel %h", wb_we_i, wb_sel_i));
      end
      // Stalled issue must hold its payload
      if (held && !fl) begin
        if (!issue_valid_i || curr_pc_i != held_pc || instruction_i != held_instr) begin
          report($sformatf("stalled pc %h changed to %h", held_pc, curr_pc_i));
        end
      end
      held       = issue_valid_i & ~issue_ready_i & ~fl;
      held_pc    = curr_pc_i;
      held_instr = instruction_i;
      if (issue_valid_i && issue_ready_i && !fl) begin
        check_issue();
      end
      // Model update with the history before this edge
      if (res_valid_i) begin
        idx = int'(res_pc_i[H+1:2] ^ ghr);
        if (res_taken_i && pht[idx] != 2'b11) begin
          pht[idx] = pht[idx] + 2'd1;
        end else if (!res_taken_i && pht[idx] != 2'b00) begin
          pht[idx] = pht[idx] - 2'd1;
        end
        if (res_taken_i) begin
          btb_pc[int'(res_pc_i[B+1:2])]  = res_pc_i;
          btb_tgt[int'(res_pc_i[B+1:2])] = res_target_i;
          btb_v[int'(res_pc_i[B+1:2])]   = 1'b1;
        end
      end
      if (bflush) begin
        ghr = '0;
        for (int i = 0; i < (1 << B); i++) begin
          btb_v[i] = 1'b0;
        end
      end else if (res_valid_i) begin
        ghr = {ghr[H-2:0], res_taken_i};
      end
      if (res_valid_i || bflush) begin
        last_change = cycle;
      end
      // Redirect fixes the next PC, a plain flush loses it
      if (fl) begin
        expect_known = redir;
        expect_pc    = res_target_i;
        redir_edge   = cycle;
        iss1         = -1;
        iss2         = -1;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_frontend.sv
// Front end testbench
// Clock, reset, Wishbone memory model and stimulus table

`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

  import frontend_pkg::*;

  localparam logic [31:0] MEM_KEY = 32'h13579bdf;
  localparam int          N_ROWS  = 11;

  logic         clk_i;
  logic         arst_n_i;
  logic         flush_i;
  logic [31:0]  wb_adr_o;
  logic         wb_cyc_o;
  logic         wb_stb_o;
  logic         wb_we_o;
  logic [3:0]   wb_sel_o;
  logic [31:0]  wb_dat_i;
  logic         wb_ack_i;
  logic         wb_err_i;
  logic         issue_ready_i;
  logic         issue_valid_o;
  logic [31:0]  instruction_o;
  logic [31:0]  curr_pc_o;
  logic         pred_taken_o;
  logic [31:0]  pred_target_o;
  logic         except_o;
  except_code_e except_code_o;
  logic         res_valid_i;
  logic [31:0]  res_pc_i;
  logic [31:0]  res_target_i;
  logic         res_taken_i;
  logic         res_mispredict_i;
  int           issue_cnt;
  int           error_cnt;

  // -------------------------------------------------------------------
  // Stimulus table
  // -------------------------------------------------------------------
  int           row_cyc [N_ROWS];
  logic [7:0]   row_pat [N_ROWS];
  logic         row_rv [N_ROWS];
  logic [31:0]  row_rpc [N_ROWS];
  logic [31:0]  row_rtgt [N_ROWS];
  logic         row_rtk [N_ROWS];
  logic         row_rmis [N_ROWS];
  logic         row_fl [N_ROWS];

  int           cycle;
  int           wait_cnt;
  int           seed;
  int           base;
  logic [7:0]   cur_pat;

  localparam int TAIL_CYCLES = 200;
  // Last table cycle plus time for the closing issues
  int           limit;

  frontend_top i_frontend_top (
    .clk_i, .arst_n_i, .flush_i,
    .wb_adr_o, .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_sel_o,
    .wb_dat_i, .wb_ack_i, .wb_err_i,
    .issue_ready_i, .issue_valid_o, .instruction_o, .curr_pc_o,
    .pred_taken_o, .pred_target_o, .except_o, .except_code_o,
    .res_valid_i, .res_pc_i, .res_target_i, .res_taken_i, .res_mispredict_i
  );

  frontend_checker #(.MEM_KEY(MEM_KEY)) i_checker (
    .clk_i, .arst_n_i, .flush_i, .issue_ready_i,
    .issue_valid_i(issue_valid_o), .instruction_i(instruction_o),
    .curr_pc_i(curr_pc_o), .pred_taken_i(pred_taken_o),
    .pred_target_i(pred_target_o), .except_i(except_o),
    .except_code_i(except_code_o), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o),
    .wb_we_i(wb_we_o), .wb_sel_i(wb_sel_o), .wb_adr_i(wb_adr_o),
    .res_valid_i, .res_pc_i, .res_target_i, .res_taken_i, .res_mispredict_i,
    .issue_cnt_o(issue_cnt), .error_cnt_o(error_cnt)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      cycle <= cycle + 1;
    end
    if (cycle > limit) begin
      $display("Timeout: run passed cycle %0d without finishing", limit);
      $display("Test failed");
      $finish;
    end
  end

  // Memory with 0 to 3 wait states, err from 32'h400 up
  always @(posedge clk_i) begin
    #1;
    if (wb_ack_i || wb_err_i) begin
      wb_ack_i = 1'b0;
      wb_err_i = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (wait_cnt == 0) begin
        wb_dat_i = wb_adr_o ^ MEM_KEY;
        wb_ack_i = (wb_adr_o < 32'h400);
        wb_err_i = (wb_adr_o >= 32'h400);
        wait_cnt = $unsigned($random(seed)) % 4;
      end else begin
        wait_cnt--;
      end
    end
  end

  task automatic add_row(input int r, input int c, input logic [7:0] pat,
                         input logic rv, input logic [31:0] rpc,
                         input logic [31:0] rtgt, input logic rtk,
                         input logic rmis, input logic fl);
    row_cyc[r]  = c;
    row_pat[r]  = pat;
    row_rv[r]   = rv;
    row_rpc[r]  = rpc;
    row_rtgt[r] = rtgt;
    row_rtk[r]  = rtk;
    row_rmis[r] = rmis;
    row_fl[r]   = fl;
  endtask

  // One cycle with pulses cleared and ready from the pattern
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
    res_valid_i      = 1'b0;
    res_mispredict_i = 1'b0;
    flush_i          = 1'b0;
    issue_ready_i    = cur_pat[cycle % 8];
  endtask

  initial begin
    seed             = 32'hf2ee9b07;
    wait_cnt         = $unsigned($random(seed)) % 4;
    cycle            = 0;
    cur_pat          = 8'hff;
    arst_n_i         = 1'b0;
    flush_i          = 1'b0;
    wb_dat_i         = '0;
    wb_ack_i         = 1'b0;
    wb_err_i         = 1'b0;
    issue_ready_i    = 1'b0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    // Sequential, back-pressure, redirect
    add_row(0, 10, 8'hff, 0, 32'h0, 32'h0, 0, 0, 0);
    add_row(1, 40, 8'h03, 0, 32'h0, 32'h0, 0, 0, 0);
    add_row(2, 70, 8'hff, 0, 32'h0, 32'h0, 0, 0, 0);
    add_row(3, 80, 8'hff, 1, 32'h20, 32'h200, 1, 1, 0);
    // Train 0x40 as taken to 0x80, history saturates first
    add_row(4, 110, 8'hff, 1, 32'h40, 32'h80, 1, 0, 0);
    add_row(5, 118, 8'hff, 1, 32'h7c, 32'h40, 1, 1, 0);
    // Plain flush, then refetch 0x40 untrained
    add_row(6, 150, 8'hff, 0, 32'h0, 32'h0, 0, 0, 1);
    add_row(7, 160, 8'hff, 1, 32'h7c, 32'h40, 1, 1, 0);
    // Access fault region, then misaligned stream, then back home
    add_row(8, 190, 8'hff, 1, 32'h300, 32'h3f8, 1, 1, 0);
    add_row(9, 220, 8'h5f, 1, 32'h304, 32'h102, 0, 1, 0);
    add_row(10, 240, 8'hff, 1, 32'h308, 32'h10, 0, 1, 0);
    limit = row_cyc[N_ROWS-1] + TAIL_CYCLES;
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    for (int r = 0; r < N_ROWS; r++) begin
      // Row 4 repeats its resolution for eight cycles
      while (cycle < row_cyc[r]) begin
        step_cycle();
      end
      for (int k = 0; k < ((r == 4) ? 8 : 1); k++) begin
        @(posedge clk_i);
        #1;
        cur_pat          = row_pat[r];
        res_valid_i      = row_rv[r];
        res_pc_i         = row_rpc[r];
        res_target_i     = row_rtgt[r];
        res_taken_i      = row_rtk[r];
        res_mispredict_i = row_rmis[r];
        flush_i          = row_fl[r];
        issue_ready_i    = cur_pat[cycle % 8];
      end
      $display("row %0d at cycle %0d: %0d issues, %0d errors", r, cycle,
               issue_cnt, error_cnt);
    end
    // Let the last redirect show up in issued words
    base = issue_cnt;
    while (issue_cnt < base + 8) begin
      step_cycle();
    end
    $display("issues %0d, errors %0d", issue_cnt, error_cnt);
    if (error_cnt == 0 && issue_cnt > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
